//--- design/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

	// Bus word
	localparam int DATA_W    = 64;
	localparam int BUS_BYTES = DATA_W / 8;
	localparam int OFFSET_W  = $clog2(BUS_BYTES); // In-word byte offset

	// AXI4 field widths
	localparam int AXI_LEN_W    = 8;
	localparam int AXI_SIZE_W   = 3;
	localparam int AXI_RESP_W   = 2;
	localparam int AXI_BURST_W  = 2;
	localparam int AXI_PROT_W   = 3;
	localparam int AXI_CACHE_W  = 4;
	localparam int AXI_QOS_W    = 4;
	localparam int AXI_REGION_W = 4;
	localparam int AXI_USER_W   = 1;

	localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'b01;

	localparam logic [AXI_RESP_W-1:0] RESP_OKAY   = 2'b00;
	localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;

	// CPU access size, 1/2/4/8 bytes
	typedef enum logic [1:0] {
		BYTE  = 2'b00,
		HALF  = 2'b01,
		WORD  = 2'b10,
		DWORD = 2'b11
	} acc_size_e;

endpackage

`default_nettype wire

//--- design/rd_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rd_beat_if;
	import axi_rd_pkg::*;

	logic                  beat_valid; // One cycle per R handshake
	logic [DATA_W-1:0]     data;
	logic [AXI_RESP_W-1:0] resp;
	logic                  last;

	// Held for the whole transaction
	logic [OFFSET_W-1:0]   offset;
	acc_size_e             size;

	modport src (
		output beat_valid, data, resp, last, offset, size
	);

	modport dst (
		input beat_valid, data, resp, last, offset, size
	);

endinterface

`default_nettype wire

//--- design/axi_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl #(
	parameter int ADDR_W = 32,
	parameter int ID_W   = 4
) (
	input  wire                                    clk,
	input  wire                                    reset_n,

	input  wire                                    cpu_ar_valid_i,
	input  wire [ID_W-1:0]                         cpu_id_i,
	input  wire [ADDR_W-1:0]                       cpu_addr_i,
	input  wire [axi_rd_pkg::AXI_LEN_W-1:0]        cpu_len_i,
	input  wire axi_rd_pkg::acc_size_e             cpu_size_i,
	output logic                                   cpu_ar_ready_o,

	output logic                                   axi_ar_valid_o,
	input  wire                                    axi_ar_ready_i,
	output logic [ID_W-1:0]                        axi_ar_id_o,
	output logic [ADDR_W-1:0]                      axi_ar_addr_o,
	output logic [axi_rd_pkg::AXI_LEN_W-1:0]       axi_ar_len_o,
	output logic [axi_rd_pkg::AXI_SIZE_W-1:0]      axi_ar_size_o,
	output logic [axi_rd_pkg::AXI_BURST_W-1:0]     axi_ar_burst_o,
	output logic [axi_rd_pkg::AXI_PROT_W-1:0]      axi_ar_prot_o,
	output logic                                   axi_ar_lock_o,
	output logic [axi_rd_pkg::AXI_CACHE_W-1:0]     axi_ar_cache_o,
	output logic [axi_rd_pkg::AXI_QOS_W-1:0]       axi_ar_qos_o,
	output logic [axi_rd_pkg::AXI_REGION_W-1:0]    axi_ar_region_o,
	output logic [axi_rd_pkg::AXI_USER_W-1:0]      axi_ar_user_o,

	output logic                                   axi_r_ready_o,
	input  wire                                    axi_r_valid_i,
	input  wire [axi_rd_pkg::DATA_W-1:0]           axi_r_data_i,
	input  wire [axi_rd_pkg::AXI_RESP_W-1:0]       axi_r_resp_i,
	input  wire                                    axi_r_last_i,

	rd_beat_if.src                                 beat_o
);
	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		ADDR = 2'b01,
		DATA = 2'b10
	} state_e;

	state_e state;
	state_e state_nxt;

	logic                  accept;
	logic                  ar_hs;
	logic                  r_hs;
	logic [AXI_SIZE_W-1:0] ar_size_nxt;

	logic [OFFSET_W-1:0]   ctx_offset;
	acc_size_e             ctx_size;

	assign cpu_ar_ready_o = (state == IDLE);
	assign axi_ar_valid_o = (state == ADDR);
	assign axi_r_ready_o  = (state == DATA);

	assign accept = cpu_ar_valid_i & cpu_ar_ready_o;
	assign ar_hs  = axi_ar_valid_o & axi_ar_ready_i;
	assign r_hs   = axi_r_valid_i & axi_r_ready_o;

	// Fixed AR attributes
	assign axi_ar_burst_o  = BURST_INCR;
	assign axi_ar_prot_o   = '0;
	assign axi_ar_lock_o   = 1'b0;
	assign axi_ar_cache_o  = '0;
	assign axi_ar_qos_o    = '0;
	assign axi_ar_region_o = '0;
	assign axi_ar_user_o   = '0;

	always_comb begin
		ar_size_nxt = 3'd0;
		case (cpu_size_i)
			BYTE:  ar_size_nxt = 3'd0;
			HALF:  ar_size_nxt = 3'd1;
			WORD:  ar_size_nxt = 3'd2;
			DWORD: ar_size_nxt = 3'd3;
			default: ar_size_nxt = 3'd0;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (accept) state_nxt = ADDR;
			ADDR: if (ar_hs) state_nxt = DATA;
			DATA: if (r_hs && axi_r_last_i) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Request capture, address aligned down to the bus word
	always_ff @(posedge clk) begin
		if (accept) begin
			axi_ar_id_o   <= cpu_id_i;
			axi_ar_addr_o <= {cpu_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
			axi_ar_len_o  <= cpu_len_i;
			axi_ar_size_o <= ar_size_nxt;
			ctx_offset    <= cpu_addr_i[OFFSET_W-1:0];
			ctx_size      <= cpu_size_i;
		end
	end

	assign beat_o.beat_valid = r_hs;
	assign beat_o.data       = axi_r_data_i;
	assign beat_o.resp       = axi_r_resp_i;
	assign beat_o.last       = axi_r_last_i;
	assign beat_o.offset     = ctx_offset;
	assign beat_o.size       = ctx_size;

	// AR payload must hold while the slave stalls
	ar_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
		(axi_ar_valid_o && !axi_ar_ready_i) |=>
			$stable({axi_ar_id_o, axi_ar_addr_o, axi_ar_len_o, axi_ar_size_o}));

	// R ready opens only after the AR handshake
	r_ready_after_ar_a: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(axi_r_ready_o) |-> $past(ar_hs));

	// A beat needs the AR phase first
	no_beat_in_idle_a: assert property (@(posedge clk) disable iff (!reset_n)
		beat_o.beat_valid |-> ($past(state) != IDLE));

endmodule

`default_nettype wire

//--- design/rd_data_align.sv
`timescale 1ns/1ps
`default_nettype none

module rd_data_align (
	input  wire                                clk,
	input  wire                                reset_n,

	rd_beat_if.dst                             beat_i,

	output logic                               cpu_r_valid_o,
	output logic [axi_rd_pkg::DATA_W-1:0]      cpu_r_data_o,
	output logic [axi_rd_pkg::AXI_RESP_W-1:0]  cpu_r_resp_o,
	output logic                               cpu_r_last_o
);
	import axi_rd_pkg::*;

	logic [BUS_BYTES-1:0]      base_lanes;
	logic [BUS_BYTES-1:0]      lane_en;
	logic [OFFSET_W:0]         span_bytes;
	logic [DATA_W-1:0]         bit_mask;

	always_comb begin
		base_lanes = '0;
		span_bytes = '0;
		case (beat_i.size)
			BYTE: begin
				base_lanes = 8'h01;
				span_bytes = 4'd1;
			end
			HALF: begin
				base_lanes = 8'h03;
				span_bytes = 4'd2;
			end
			WORD: begin
				base_lanes = 8'h0f;
				span_bytes = 4'd4;
			end
			DWORD: begin
				base_lanes = 8'hff;
				span_bytes = 4'd8;
			end
			default: begin
				base_lanes = '0;
				span_bytes = '0;
			end
		endcase
	end

	assign lane_en = base_lanes << beat_i.offset; // Data stays in its lanes

	always_comb begin
		for (int i = 0; i < BUS_BYTES; i++) begin
			bit_mask[i*8 +: 8] = {8{lane_en[i]}};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
			cpu_r_last_o  <= 1'b0;
		end else begin
			cpu_r_valid_o <= beat_i.beat_valid;
			cpu_r_last_o  <= beat_i.beat_valid & beat_i.last;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_i.beat_valid) begin
			cpu_r_data_o <= beat_i.data & bit_mask;
			cpu_r_resp_o <= beat_i.resp;
		end
	end

	// Misaligned access would spill into the next word
	span_in_word_a: assert property (@(posedge clk) disable iff (!reset_n)
		beat_i.beat_valid |-> ({1'b0, beat_i.offset} + span_bytes) <= BUS_BYTES);

endmodule

`default_nettype wire

//--- design/axi_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_top #(
	parameter int ADDR_W = 32,
	parameter int ID_W   = 4
) (
	input  wire                                    clk,
	input  wire                                    reset_n,

	// CPU request
	input  wire                                    cpu_ar_valid_i,
	input  wire [ID_W-1:0]                         cpu_id_i,
	input  wire [ADDR_W-1:0]                       cpu_addr_i,
	input  wire [axi_rd_pkg::AXI_LEN_W-1:0]        cpu_len_i,
	input  wire axi_rd_pkg::acc_size_e             cpu_size_i,
	output logic                                   cpu_ar_ready_o,

	// CPU read data
	output logic                                   cpu_r_valid_o,
	output logic [axi_rd_pkg::DATA_W-1:0]          cpu_r_data_o,
	output logic [axi_rd_pkg::AXI_RESP_W-1:0]      cpu_r_resp_o,
	output logic                                   cpu_r_last_o,

	// AXI AR
	output logic                                   axi_ar_valid_o,
	input  wire                                    axi_ar_ready_i,
	output logic [ID_W-1:0]                        axi_ar_id_o,
	output logic [ADDR_W-1:0]                      axi_ar_addr_o,
	output logic [axi_rd_pkg::AXI_LEN_W-1:0]       axi_ar_len_o,
	output logic [axi_rd_pkg::AXI_SIZE_W-1:0]      axi_ar_size_o,
	output logic [axi_rd_pkg::AXI_BURST_W-1:0]     axi_ar_burst_o,
	output logic [axi_rd_pkg::AXI_PROT_W-1:0]      axi_ar_prot_o,
	output logic                                   axi_ar_lock_o,
	output logic [axi_rd_pkg::AXI_CACHE_W-1:0]     axi_ar_cache_o,
	output logic [axi_rd_pkg::AXI_QOS_W-1:0]       axi_ar_qos_o,
	output logic [axi_rd_pkg::AXI_REGION_W-1:0]    axi_ar_region_o,
	output logic [axi_rd_pkg::AXI_USER_W-1:0]      axi_ar_user_o,

	// AXI R
	output logic                                   axi_r_ready_o,
	input  wire                                    axi_r_valid_i,
	input  wire [axi_rd_pkg::DATA_W-1:0]           axi_r_data_i,
	input  wire [axi_rd_pkg::AXI_RESP_W-1:0]       axi_r_resp_i,
	input  wire                                    axi_r_last_i,
	input  wire [ID_W-1:0]                         axi_r_id_i
);

	rd_beat_if rd_beat_if_i ();

	axi_read_ctrl #(
		.ADDR_W (ADDR_W),
		.ID_W   (ID_W)
	) axi_read_ctrl_i (
		.clk             (clk),
		.reset_n         (reset_n),
		.cpu_ar_valid_i  (cpu_ar_valid_i),
		.cpu_id_i        (cpu_id_i),
		.cpu_addr_i      (cpu_addr_i),
		.cpu_len_i       (cpu_len_i),
		.cpu_size_i      (cpu_size_i),
		.cpu_ar_ready_o  (cpu_ar_ready_o),
		.axi_ar_valid_o  (axi_ar_valid_o),
		.axi_ar_ready_i  (axi_ar_ready_i),
		.axi_ar_id_o     (axi_ar_id_o),
		.axi_ar_addr_o   (axi_ar_addr_o),
		.axi_ar_len_o    (axi_ar_len_o),
		.axi_ar_size_o   (axi_ar_size_o),
		.axi_ar_burst_o  (axi_ar_burst_o),
		.axi_ar_prot_o   (axi_ar_prot_o),
		.axi_ar_lock_o   (axi_ar_lock_o),
		.axi_ar_cache_o  (axi_ar_cache_o),
		.axi_ar_qos_o    (axi_ar_qos_o),
		.axi_ar_region_o (axi_ar_region_o),
		.axi_ar_user_o   (axi_ar_user_o),
		.axi_r_ready_o   (axi_r_ready_o),
		.axi_r_valid_i   (axi_r_valid_i),
		.axi_r_data_i    (axi_r_data_i),
		.axi_r_resp_i    (axi_r_resp_i),
		.axi_r_last_i    (axi_r_last_i),
		.beat_o          (rd_beat_if_i.src)
	);

	rd_data_align rd_data_align_i (
		.clk           (clk),
		.reset_n       (reset_n),
		.beat_i        (rd_beat_if_i.dst),
		.cpu_r_valid_o (cpu_r_valid_o),
		.cpu_r_data_o  (cpu_r_data_o),
		.cpu_r_resp_o  (cpu_r_resp_o),
		.cpu_r_last_o  (cpu_r_last_o)
	);

	// Single outstanding read, so every beat must carry the issued id
	r_id_match_a: assert property (@(posedge clk) disable iff (!reset_n)
		(axi_r_valid_i && axi_r_ready_o) |-> (axi_r_id_i == axi_ar_id_o));

endmodule

`default_nettype wire

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
	parameter int          ADDR_W   = 32,
	parameter int          ID_W     = 4,
	parameter logic [31:0] ERR_BASE = 32'h0000_0600,
	parameter logic [31:0] SEED     = 32'h0000_0001
) (
	input  wire                                clk,
	input  wire                                reset_n,
	input  wire                                ar_valid_i,
	output logic                               ar_ready_o,
	input  wire [ID_W-1:0]                     ar_id_i,
	input  wire [ADDR_W-1:0]                   ar_addr_i,
	input  wire [axi_rd_pkg::AXI_LEN_W-1:0]    ar_len_i,
	output logic                               r_valid_o,
	input  wire                                r_ready_i,
	output logic [axi_rd_pkg::DATA_W-1:0]      r_data_o,
	output logic [axi_rd_pkg::AXI_RESP_W-1:0]  r_resp_o,
	output logic                               r_last_o,
	output logic [ID_W-1:0]                    r_id_o
);
	import axi_rd_pkg::*;

	logic [DATA_W-1:0]    mem [0:255];
	logic                 busy;
	logic [ADDR_W-1:0]    cur_addr; // Address of the next beat
	logic [AXI_LEN_W-1:0] beats_left;
	integer               seed;

	function automatic logic [63:0] fill_word(input logic [31:0] idx);
		return {idx ^ 32'h3c5a_a5c3, idx * 32'h9e37_79b9 + 32'h0123_4567};
	endfunction

	initial begin
		seed       = SEED;
		busy       = 1'b0;
		cur_addr   = '0;
		beats_left = '0;
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_data_o   = '0;
		r_resp_o   = RESP_OKAY;
		r_last_o   = 1'b0;
		r_id_o     = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
	end

	always @(posedge clk) begin
		if (!reset_n) begin
			ar_ready_o <= 1'b0;
			r_valid_o  <= 1'b0;
			r_last_o   <= 1'b0;
			busy       <= 1'b0;
		end else begin
			// One burst at a time, random AR stalls
			ar_ready_o <= !busy && !(ar_valid_i && ar_ready_o) && (($random(seed) & 3) != 0);
			if (ar_valid_i && ar_ready_o) begin
				busy       <= 1'b1;
				cur_addr   <= ar_addr_i;
				beats_left <= ar_len_i;
				r_id_o     <= ar_id_i;
			end
			if (r_valid_o && r_ready_i) begin
				r_valid_o  <= 1'b0;
				cur_addr   <= cur_addr + 8; // INCR
				beats_left <= beats_left - 1;
				if (r_last_o)
					busy <= 1'b0;
			end else if (busy && !r_valid_o && ($random(seed) & 1)) begin
				r_valid_o <= 1'b1;
				r_data_o  <= mem[cur_addr[10:3]];
				r_resp_o  <= (cur_addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
				r_last_o  <= (beats_left == 0);
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/axi_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_tb;
	import axi_rd_pkg::*;

	localparam int          ADDR_W   = 32;
	localparam int          ID_W     = 4;
	localparam int          MAX_LEN  = 15;
	localparam int          N_RAND   = 40;
	localparam int          N_REQ    = 15 + 2 + N_RAND; // Sweep, limit crossing, random
	localparam logic [31:0] ERR_BASE = 32'h0000_0600;

	logic                      clk = 1'b0;
	logic                      reset_n;
	logic                      cpu_ar_valid_i;
	logic [ID_W-1:0]           cpu_id_i;
	logic [ADDR_W-1:0]         cpu_addr_i;
	logic [AXI_LEN_W-1:0]      cpu_len_i;
	acc_size_e                 cpu_size_i;
	logic                      cpu_ar_ready_o;
	logic                      cpu_r_valid_o;
	logic [DATA_W-1:0]         cpu_r_data_o;
	logic [AXI_RESP_W-1:0]     cpu_r_resp_o;
	logic                      cpu_r_last_o;
	logic                      axi_ar_valid_o;
	logic                      axi_ar_ready_i;
	logic [ID_W-1:0]           axi_ar_id_o;
	logic [ADDR_W-1:0]         axi_ar_addr_o;
	logic [AXI_LEN_W-1:0]      axi_ar_len_o;
	logic [AXI_SIZE_W-1:0]     axi_ar_size_o;
	logic [AXI_BURST_W-1:0]    axi_ar_burst_o;
	logic [AXI_PROT_W-1:0]     axi_ar_prot_o;
	logic                      axi_ar_lock_o;
	logic [AXI_CACHE_W-1:0]    axi_ar_cache_o;
	logic [AXI_QOS_W-1:0]      axi_ar_qos_o;
	logic [AXI_REGION_W-1:0]   axi_ar_region_o;
	logic [AXI_USER_W-1:0]     axi_ar_user_o;
	logic                      axi_r_ready_o;
	logic                      axi_r_valid_i;
	logic [DATA_W-1:0]         axi_r_data_i;
	logic [AXI_RESP_W-1:0]     axi_r_resp_i;
	logic                      axi_r_last_i;
	logic [ID_W-1:0]           axi_r_id_i;

	// Current request, one in flight
	logic [ADDR_W-1:0] req_addr;
	logic [ID_W-1:0]   req_id;
	int                req_len;
	acc_size_e         req_size;
	logic [ADDR_W-1:0] beat_addr;
	int                beat_idx = 0;
	int                issued = 0;
	int                reqs_done = 0;
	int                okay_seen = 0;
	int                err_seen = 0;
	bit                in_flight = 0;
	integer            seed = 32'hb4d5_1458;

	axi_read_top #(.ADDR_W(ADDR_W), .ID_W(ID_W)) axi_read_top_i (.*);

	axi_mem_model #(
		.ADDR_W(ADDR_W), .ID_W(ID_W), .ERR_BASE(ERR_BASE), .SEED(32'hb4d5_1458)
	) mem_model_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.ar_valid_i (axi_ar_valid_o),
		.ar_ready_o (axi_ar_ready_i),
		.ar_id_i    (axi_ar_id_o),
		.ar_addr_i  (axi_ar_addr_o),
		.ar_len_i   (axi_ar_len_o),
		.r_valid_o  (axi_r_valid_i),
		.r_ready_i  (axi_r_ready_o),
		.r_data_o   (axi_r_data_i),
		.r_resp_o   (axi_r_resp_i),
		.r_last_o   (axi_r_last_i),
		.r_id_o     (axi_r_id_i)
	);

	always #20 clk = ~clk;

	function automatic logic [63:0] pattern_word(input logic [31:0] idx);
		return {idx ^ 32'h3c5a_a5c3, idx * 32'h9e37_79b9 + 32'h0123_4567};
	endfunction

	function automatic int size_bytes(input acc_size_e size);
		case (size)
			BYTE:    return 1;
			HALF:    return 2;
			WORD:    return 4;
			default: return 8;
		endcase
	endfunction

	// Selected lanes keep their data, the rest read as zero
	function automatic logic [63:0] ref_data(input logic [63:0] word, input logic [2:0] offset,
			input acc_size_e size);
		logic [63:0] masked;
		masked = '0;
		for (int i = 0; i < 8; i++) begin
			if (i >= offset && i < offset + size_bytes(size))
				masked[i*8 +: 8] = word[i*8 +: 8];
		end
		return masked;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic issue_read(input logic [ID_W-1:0] id, input logic [31:0] addr,
			input int len, input int sz);
		@(posedge clk);
		#1;
		req_addr       = addr;
		req_id         = id;
		req_len        = len;
		req_size       = acc_size_e'(sz);
		cpu_ar_valid_i = 1'b1;
		cpu_id_i       = id;
		cpu_addr_i     = addr;
		cpu_len_i      = len;
		cpu_size_i     = acc_size_e'(sz);
		@(negedge clk);
		while (!cpu_ar_ready_o)
			@(negedge clk);
		@(posedge clk);
		#1;
		cpu_ar_valid_i = 1'b0;
		issued++;
		wait (reqs_done == issued);
	endtask

	always @(negedge clk) begin
		if (reset_n) begin
			if (axi_ar_valid_o && axi_ar_ready_i) begin
				check_value("axi_ar_id_o", axi_ar_id_o, req_id);
				check_value("axi_ar_addr_o", axi_ar_addr_o, {req_addr[ADDR_W-1:3], 3'b000});
				check_value("axi_ar_len_o", axi_ar_len_o, req_len);
				check_value("axi_ar_size_o", axi_ar_size_o, $clog2(size_bytes(req_size)));
				check_value("axi_ar_burst_o", axi_ar_burst_o, BURST_INCR);
				check_value("axi_ar_prot_o", axi_ar_prot_o, 0);
				check_value("axi_ar_lock_o", axi_ar_lock_o, 0);
				check_value("axi_ar_cache_o", axi_ar_cache_o, 0);
				check_value("axi_ar_qos_o", axi_ar_qos_o, 0);
				check_value("axi_ar_region_o", axi_ar_region_o, 0);
				check_value("axi_ar_user_o", axi_ar_user_o, 0);
			end
			if (cpu_r_valid_o) begin
				if (!in_flight)
					fail_run("read data pulse arrived with no request in flight");
				beat_addr = {req_addr[ADDR_W-1:3], 3'b000} + beat_idx * 8;
				check_value("cpu_r_data_o", cpu_r_data_o,
					ref_data(pattern_word(beat_addr >> 3), req_addr[2:0], req_size));
				check_value("cpu_r_resp_o", cpu_r_resp_o,
					(beat_addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY);
				check_value("cpu_r_last_o", cpu_r_last_o, beat_idx == req_len);
				if (cpu_r_resp_o == RESP_SLVERR)
					err_seen++;
				else
					okay_seen++;
				beat_idx++;
			end
			if (in_flight) begin
				if (cpu_r_valid_o && cpu_r_last_o) begin
					check_value("cpu_ar_ready_o", cpu_ar_ready_o, 1); // Back in IDLE with the last pulse
					in_flight = 0;
					beat_idx  = 0;
					reqs_done++;
				end else begin
					check_value("cpu_ar_ready_o", cpu_ar_ready_o, 0);
				end
			end
			if (cpu_ar_valid_i && cpu_ar_ready_o)
				in_flight = 1; // Accepted on the coming edge
		end
	end

	initial begin
		repeat (N_REQ * (MAX_LEN + 1) * 40) @(posedge clk);
		fail_run("timeout: the read requests did not all complete in time");
	end

	initial begin
		int sz;
		int len;
		int off;
		int idx;
		reset_n        = 1'b0;
		cpu_ar_valid_i = 1'b0;
		cpu_id_i       = '0;
		cpu_addr_i     = '0;
		cpu_len_i      = '0;
		cpu_size_i     = BYTE;
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;
		@(negedge clk);
		check_value("cpu_ar_ready_o", cpu_ar_ready_o, 1);
		check_value("axi_ar_valid_o", axi_ar_valid_o, 0);
		check_value("axi_r_ready_o", axi_r_ready_o, 0);
		check_value("cpu_r_valid_o", cpu_r_valid_o, 0);
		check_value("cpu_r_last_o", cpu_r_last_o, 0);

		// Every size at every aligned offset
		for (sz = 0; sz < 4; sz++) begin
			for (off = 0; off < 8; off += (1 << sz)) begin
				idx = ($random(seed) & 32'h7fff_ffff) % 240;
				issue_read($random(seed), idx * 8 + off, 0, sz);
			end
		end

		issue_read(4'h3, 32'h0000_05f8, 0, 3); // Last word below the limit
		issue_read(4'h9, 32'h0000_05f0, 3, 3); // Burst across the limit

		for (int n = 0; n < N_RAND; n++) begin
			sz  = $random(seed) & 3;
			len = $random(seed) & MAX_LEN;
			off = ($random(seed) & 7) & ~((1 << sz) - 1);
			idx = ($random(seed) & 32'h7fff_ffff) % 240;
			issue_read($random(seed), idx * 8 + off, len, sz);
		end

		repeat (2) @(posedge clk);
		if (okay_seen == 0 || err_seen == 0) begin
			fail_run("responses did not include both OKAY and SLVERR");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- files.f
design/axi_rd_pkg.sv
design/rd_beat_if.sv
design/axi_read_ctrl.sv
design/rd_data_align.sv
design/axi_read_top.sv
verification/axi_mem_model.sv
verification/axi_read_tb.sv
